/* issue_dispatch.f */
hdl/issue_cfg_pkg.sv
hdl/issue_types_pkg.sv
hdl/batch_capture.sv
hdl/slot_classify.sv
hdl/class_compact.sv
hdl/issue_queues.sv
hdl/issue_dispatch_top.sv
verification/issue_dispatch_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f issue_dispatch.f \
    --top-module issue_dispatch_tb -o issue_dispatch_sim

out=$(./obj_dir/issue_dispatch_sim)
echo "$out"
echo "$out" | grep -qx "NO ERRORS"

/* verification/issue_dispatch_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_dispatch_tb;

    localparam int n_tests        = 10;
    localparam int timeout_cycles = 40 * n_tests + 50;

    typedef struct packed {
        logic [3:0] first;
        logic [3:0] start;
        logic [3:0] stop;
        logic       restart;
        logic       b2b;     // strobe in the cycle after the previous entry
    } entry_t;

    typedef struct packed {
        logic [4:0]        lsu_cnt;
        logic [4:0]        csr_cnt;
        logic [15:0]       alu_valid;
        logic              ovf;
        logic [15:0][31:0] lsu;   // entries past the count are 0
        logic [15:0][31:0] csr;
        logic [15:0][31:0] alu;   // invalid slots are 0
    } state_t;

    logic                                  w_fire00;
    logic                                  rstn;
    logic                                  i_batch_valid;
    issue_types_pkg::instr_vec_t           i_batch_instr;
    logic [3:0]                            i_branch_first;
    logic [3:0]                            i_branch_start;
    logic [3:0]                            i_branch_stop;
    logic                                  i_branch_restart;
    issue_types_pkg::queue_sel_e           i_rd_queue;
    logic [3:0]                            i_rd_idx;
    wire                                   o_batch_done;
    wire  [4:0]                            o_lsu_count;
    wire  [4:0]                            o_csr_count;
    wire  [15:0]                           o_alu_valid;
    wire                                   o_overflow;
    wire  [31:0]                           o_rd_instr;

    entry_t tab[$];
    string  tab_name[$];
    string  tab_pat[$];    // one char per slot, slot 0 first

    // reference model state
    logic [31:0] m_lsu [16];
    logic [31:0] m_csr [16];
    logic [31:0] m_alu [16];
    int          m_lsu_cnt;
    int          m_csr_cnt;
    logic [15:0] m_alu_valid;
    logic        m_ovf;
    logic        m_first_flag;

    int     exp_done_q[$];
    int     exp_test_q[$];
    state_t exp_state_q[$];

    int cyc;
    int value_errors;
    int other_errors;

    logic [6:0] alu_opc [4] = '{7'b0110011, 7'b0010011, 7'b0110111, 7'b1100011};

    issue_dispatch_top issue_dispatch_top_i (
        .w_fire00         (w_fire00),
        .rstn             (rstn),
        .i_batch_valid    (i_batch_valid),
        .i_batch_instr    (i_batch_instr),
        .i_branch_first   (i_branch_first),
        .i_branch_start   (i_branch_start),
        .i_branch_stop    (i_branch_stop),
        .i_branch_restart (i_branch_restart),
        .i_rd_queue       (i_rd_queue),
        .i_rd_idx         (i_rd_idx),
        .o_batch_done     (o_batch_done),
        .o_lsu_count      (o_lsu_count),
        .o_csr_count      (o_csr_count),
        .o_alu_valid      (o_alu_valid),
        .o_overflow       (o_overflow),
        .o_rd_instr       (o_rd_instr)
    );

    always #2 w_fire00 = ~w_fire00;

    task automatic finish_run();
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    always @(posedge w_fire00) begin
        cyc++;
        if (cyc >= timeout_cycles) begin
            other_errors++;
            $display("timeout: the run did not end within %0d cycles", timeout_cycles);
            finish_run();
        end
    end

    task automatic add_entry(string name, string pat, int first, int start, int stop,
                             bit restart, bit b2b);
        entry_t e;
        e.first   = 4'(first);
        e.start   = 4'(start);
        e.stop    = 4'(stop);
        e.restart = restart;
        e.b2b     = b2b;
        tab.push_back(e);
        tab_name.push_back(name);
        tab_pat.push_back(pat);
    endtask

    task automatic check_value(string name, string what, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            value_errors++;
            $display("FAIL %s %s: expected %h, actual %h", name, what, exp, act);
        end
    endtask

    task automatic check_state(string name, state_t s);
        check_value(name, "lsu count", 32'(s.lsu_cnt), 32'(o_lsu_count));
        check_value(name, "csr count", 32'(s.csr_cnt), 32'(o_csr_count));
        check_value(name, "alu valid", 32'(s.alu_valid), 32'(o_alu_valid));
        check_value(name, "overflow", 32'(s.ovf), 32'(o_overflow));
    endtask

    // walks the read port in the low clock phase while the state holds
    task automatic scan_queues(string name, state_t s);
        string       qname;
        logic [31:0] exp_word;
        for (int q = 0; q < 3; q++) begin
            for (int i = 0; i < 16; i++) begin
                case (q)
                    0: begin
                        i_rd_queue = issue_types_pkg::q_lsu;
                        qname      = "lsu";
                        exp_word   = s.lsu[i];
                    end
                    1: begin
                        i_rd_queue = issue_types_pkg::q_csr;
                        qname      = "csr";
                        exp_word   = s.csr[i];
                    end
                    default: begin
                        i_rd_queue = issue_types_pkg::q_alu;
                        qname      = "alu";
                        exp_word   = s.alu[i];
                    end
                endcase
                i_rd_idx = 4'(i);
                #0.02;
                check_value(name, $sformatf("%s[%0d]", qname, i), exp_word, o_rd_instr);
            end
        end
    endtask

    // advances to the next falling edge and checks the done pulse there
    task automatic next_cycle();
        logic   expect_done;
        state_t s;
        int     t;
        @(negedge w_fire00);
        expect_done = (exp_done_q.size() > 0) && (exp_done_q[0] == cyc);
        assert (o_batch_done === expect_done) else begin
            other_errors++;
            $display("o_batch_done is %0b at cycle %0d but should be %0b",
                     o_batch_done, cyc, expect_done);
        end
        if (expect_done) begin
            void'(exp_done_q.pop_front());
            t = exp_test_q.pop_front();
            s = exp_state_q.pop_front();
            check_state(tab_name[t], s);
            scan_queues(tab_name[t], s);
        end
    endtask

    task automatic model_batch(int t);
        logic  is_first;
        logic  in_win;
        string pat;
        byte   c;
        pat          = tab_pat[t];
        is_first     = m_first_flag;
        m_first_flag = 1'b0;
        if (is_first) begin
            m_lsu_cnt   = 0;
            m_csr_cnt   = 0;
            m_alu_valid = '0;
            m_ovf       = 1'b0;
        end
        for (int i = 0; i < 16; i++) begin
            if (is_first) begin
                in_win = (i <= int'(tab[t].first));
            end else if (tab[t].start <= tab[t].stop) begin
                in_win = (i >= int'(tab[t].start)) && (i <= int'(tab[t].stop));
            end else begin
                in_win = (i >= int'(tab[t].start)) || (i <= int'(tab[t].stop));
            end
            c = pat[i];
            if (!in_win) begin
                continue;
            end
            if (c == "L" || c == "S" || c == "A") begin
                if (m_lsu_cnt < 16) begin
                    m_lsu[m_lsu_cnt] = i_batch_instr[i];
                    m_lsu_cnt++;
                end else begin
                    m_ovf = 1'b1;   // dropped entry
                end
            end else if (c == "Y") begin
                if (m_csr_cnt < 16) begin
                    m_csr[m_csr_cnt] = i_batch_instr[i];
                    m_csr_cnt++;
                end else begin
                    m_ovf = 1'b1;
                end
            end else begin
                m_alu[i]       = i_batch_instr[i];
                m_alu_valid[i] = 1'b1;
            end
        end
    endtask

    task automatic drive_batch(int t);
        string       pat;
        logic [31:0] word;
        int unsigned r;
        state_t      s;
        pat = tab_pat[t];
        for (int i = 0; i < 16; i++) begin
            word = $urandom;
            r    = $urandom;
            case (pat[i])
                "L":     word[6:0] = issue_cfg_pkg::opc_load;
                "S":     word[6:0] = issue_cfg_pkg::opc_store;
                "A":     word[6:0] = issue_cfg_pkg::opc_amo;
                "Y":     word[6:0] = issue_cfg_pkg::opc_system;
                default: word[6:0] = alu_opc[r[1:0]];
            endcase
            i_batch_instr[i] = word;
        end
        i_batch_valid  = 1'b1;
        i_branch_first = tab[t].first;
        i_branch_start = tab[t].start;
        i_branch_stop  = tab[t].stop;
        model_batch(t);
        s.lsu_cnt   = 5'(m_lsu_cnt);
        s.csr_cnt   = 5'(m_csr_cnt);
        s.alu_valid = m_alu_valid;
        s.ovf       = m_ovf;
        for (int i = 0; i < 16; i++) begin
            s.lsu[i] = (i < m_lsu_cnt) ? m_lsu[i] : 32'h0;
            s.csr[i] = (i < m_csr_cnt) ? m_csr[i] : 32'h0;
            s.alu[i] = m_alu_valid[i] ? m_alu[i] : 32'h0;
        end
        exp_done_q.push_back(cyc + 4);   // done shows 3 edges after the capture edge
        exp_test_q.push_back(t);
        exp_state_q.push_back(s);
    endtask

    task automatic fill_table();
        add_entry("first_full",    "LY.S.AY.L..S.YA.", 15, 0, 0, 0, 0);
        add_entry("first_small",   "..LY.SLLY.A.SY..", 4, 0, 0, 1, 0);
        add_entry("later_inrange", "LLL.SY.AY..LLLLL", 0, 3, 9, 0, 0);
        add_entry("later_wrap",    "S.Y..........LA.", 0, 12, 2, 0, 0);
        add_entry("overflow_a",    "LLLL....Y.......", 0, 0, 15, 0, 0);
        add_entry("overflow_b",    "LLLLLLLL.Y......", 0, 0, 15, 0, 0);
        add_entry("restart_clear", "..Y.L..A.....LLL", 7, 0, 0, 1, 0);
        add_entry("b2b_0",         "L.Y.SA..Y.LL..A.", 0, 2, 10, 0, 0);
        add_entry("b2b_1",         ".LY..S.A.Y..L.S.", 0, 11, 5, 0, 1);
        add_entry("b2b_2",         "YYL.A..L.S.Y..LA", 0, 4, 9, 0, 1);
    endtask

    initial begin
        void'($urandom(15809));
        w_fire00         = 1'b0;
        rstn             = 1'b0;
        i_batch_valid    = 1'b0;
        i_batch_instr    = '0;
        i_branch_first   = '0;
        i_branch_start   = '0;
        i_branch_stop    = '0;
        i_branch_restart = 1'b0;
        i_rd_queue       = issue_types_pkg::q_lsu;
        i_rd_idx         = '0;
        cyc              = 0;
        value_errors     = 0;
        other_errors     = 0;
        m_lsu_cnt        = 0;
        m_csr_cnt        = 0;
        m_alu_valid      = '0;
        m_ovf            = 1'b0;
        m_first_flag     = 1'b1;   // first batch after reset
        fill_table();

        repeat (4) @(negedge w_fire00);
        rstn = 1'b1;
        next_cycle();
        check_state("reset", '0);

        for (int t = 0; t < tab.size(); t++) begin
            if (tab[t].restart) begin
                next_cycle();
                i_batch_valid    = 1'b0;
                i_branch_restart = 1'b1;
                m_first_flag     = 1'b1;
            end
            next_cycle();
            i_branch_restart = 1'b0;
            drive_batch(t);
            if (t + 1 < tab.size() && tab[t + 1].b2b) begin
                continue;
            end
            next_cycle();
            i_batch_valid = 1'b0;
            while (exp_done_q.size() > 0) begin
                next_cycle();
            end
        end

        repeat (2) next_cycle();
        finish_run();
    end

endmodule

`default_nettype wire

/* hdl/issue_dispatch_top.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_dispatch_top (
    input  wire                                  w_fire00,
    input  wire                                  rstn,
    input  wire                                  i_batch_valid,
    input  wire issue_types_pkg::instr_vec_t     i_batch_instr,
    input  wire [issue_cfg_pkg::slot_idx_w-1:0]  i_branch_first,
    input  wire [issue_cfg_pkg::slot_idx_w-1:0]  i_branch_start,
    input  wire [issue_cfg_pkg::slot_idx_w-1:0]  i_branch_stop,
    input  wire                                  i_branch_restart,
    input  wire issue_types_pkg::queue_sel_e     i_rd_queue,
    input  wire [issue_cfg_pkg::slot_idx_w-1:0]  i_rd_idx,
    output wire                                  o_batch_done,
    output wire [issue_cfg_pkg::count_w-1:0]     o_lsu_count,
    output wire [issue_cfg_pkg::count_w-1:0]     o_csr_count,
    output wire [issue_cfg_pkg::slot_count-1:0]  o_alu_valid,
    output wire                                  o_overflow,
    output wire [issue_cfg_pkg::instr_w-1:0]     o_rd_instr
);

    wire issue_types_pkg::batch_t      w_batch;
    wire                               w_batch_valid;
    wire issue_types_pkg::classified_t w_cls;
    wire                               w_cls_valid;
    wire issue_types_pkg::compacted_t  w_cmp;

    batch_capture batch_capture_i (
        .w_fire00         (w_fire00),
        .rstn             (rstn),
        .i_batch_valid    (i_batch_valid),
        .i_batch_instr    (i_batch_instr),
        .i_branch_first   (i_branch_first),
        .i_branch_start   (i_branch_start),
        .i_branch_stop    (i_branch_stop),
        .i_branch_restart (i_branch_restart),
        .o_batch          (w_batch),
        .o_valid          (w_batch_valid)
    );

    slot_classify slot_classify_i (
        .w_fire00 (w_fire00),
        .rstn     (rstn),
        .i_batch  (w_batch),
        .i_valid  (w_batch_valid),
        .o_cls    (w_cls),
        .o_valid  (w_cls_valid)
    );

    class_compact class_compact_i (
        .w_fire00 (w_fire00),
        .rstn     (rstn),
        .i_cls    (w_cls),
        .i_valid  (w_cls_valid),
        .o_cmp    (w_cmp)
    );

    // queue write lands 3 edges after capture
    issue_queues issue_queues_i (
        .w_fire00     (w_fire00),
        .rstn         (rstn),
        .i_cmp        (w_cmp),
        .i_rd_queue   (i_rd_queue),
        .i_rd_idx     (i_rd_idx),
        .o_batch_done (o_batch_done),
        .o_lsu_count  (o_lsu_count),
        .o_csr_count  (o_csr_count),
        .o_alu_valid  (o_alu_valid),
        .o_overflow   (o_overflow),
        .o_rd_instr   (o_rd_instr)
    );

endmodule

`default_nettype wire

/* hdl/issue_queues.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_queues (
    input  wire                                 w_fire00,
    input  wire                                 rstn,
    input  wire issue_types_pkg::compacted_t    i_cmp,
    input  wire issue_types_pkg::queue_sel_e    i_rd_queue,
    input  wire [issue_cfg_pkg::slot_idx_w-1:0] i_rd_idx,
    output logic                                o_batch_done,
    output logic [issue_cfg_pkg::count_w-1:0]   o_lsu_count,
    output logic [issue_cfg_pkg::count_w-1:0]   o_csr_count,
    output logic [issue_cfg_pkg::slot_count-1:0] o_alu_valid,
    output logic                                o_overflow,
    output logic [issue_cfg_pkg::instr_w-1:0]   o_rd_instr
);

    localparam int nq = issue_cfg_pkg::list_queue_count;
    localparam int cw = issue_cfg_pkg::count_w;

    logic [issue_cfg_pkg::instr_w-1:0] r_list [nq][issue_cfg_pkg::queue_depth];
    logic [cw-1:0]                     r_count [nq];
    issue_types_pkg::instr_vec_t       r_alu_q;
    logic [issue_cfg_pkg::slot_count-1:0] r_alu_valid;
    logic                              r_overflow;
    logic                              r_done;

    issue_types_pkg::instr_vec_t       w_in_list [nq];
    logic [cw-1:0]                     w_in_count [nq];
    logic [cw-1:0]                     w_base [nq];
    logic [cw:0]                       w_sum [nq];
    logic [cw-1:0]                     w_next [nq];
    logic [nq-1:0]                     w_drop;
    logic [issue_cfg_pkg::slot_idx_w-1:0] w_pos [nq][issue_cfg_pkg::slot_count];
    logic [nq-1:0][issue_cfg_pkg::slot_count-1:0] w_wr;

    always_comb begin
        logic [cw:0] pos_full;
        w_in_list[issue_cfg_pkg::lsu_q_id]  = i_cmp.lsu_list;
        w_in_count[issue_cfg_pkg::lsu_q_id] = i_cmp.lsu_count;
        w_in_list[issue_cfg_pkg::csr_q_id]  = i_cmp.csr_list;
        w_in_count[issue_cfg_pkg::csr_q_id] = i_cmp.csr_count;
        for (int q = 0; q < nq; q++) begin
            w_base[q] = i_cmp.is_first ? '0 : r_count[q];   // first batch restarts at 0
            w_sum[q]  = {1'b0, w_base[q]} + {1'b0, w_in_count[q]};
            w_drop[q] = w_sum[q] > (cw + 1)'(issue_cfg_pkg::queue_depth);
            w_next[q] = w_drop[q] ? cw'(issue_cfg_pkg::queue_depth) : w_sum[q][cw-1:0];
            for (int j = 0; j < issue_cfg_pkg::slot_count; j++) begin
                pos_full    = {1'b0, w_base[q]} + (cw + 1)'(j);
                w_pos[q][j] = pos_full[issue_cfg_pkg::slot_idx_w-1:0];
                w_wr[q][j]  = (cw'(j) < w_in_count[q]) &&
                              (pos_full < (cw + 1)'(issue_cfg_pkg::queue_depth));
            end
        end
    end

    always_ff @(posedge w_fire00 or negedge rstn) begin
        if (!rstn) begin
            for (int q = 0; q < nq; q++) begin
                r_count[q] <= '0;
            end
            r_alu_valid <= '0;
            r_overflow  <= 1'b0;
            r_done      <= 1'b0;
        end else begin
            r_done <= i_cmp.valid;
            if (i_cmp.valid) begin
                for (int q = 0; q < nq; q++) begin
                    r_count[q] <= w_next[q];
                end
                r_alu_valid <= (i_cmp.is_first ? '0 : r_alu_valid) | i_cmp.alu_mask;
                r_overflow  <= (r_overflow & ~i_cmp.is_first) | (|w_drop);   // sticky
            end
        end
    end

    always_ff @(posedge w_fire00) begin
        if (i_cmp.valid) begin
            for (int q = 0; q < nq; q++) begin
                for (int j = 0; j < issue_cfg_pkg::slot_count; j++) begin
                    if (w_wr[q][j]) begin
                        r_list[q][w_pos[q][j]] <= w_in_list[q][j];
                    end
                end
            end
            for (int i = 0; i < issue_cfg_pkg::slot_count; i++) begin
                if (i_cmp.alu_mask[i]) begin
                    r_alu_q[i] <= i_cmp.alu_instr[i];
                end
            end
        end
    end

    // entries past the fill count read as zero
    always_comb begin
        o_rd_instr = '0;
        case (i_rd_queue)
            issue_types_pkg::q_lsu: begin
                if ({1'b0, i_rd_idx} < r_count[issue_cfg_pkg::lsu_q_id]) begin
                    o_rd_instr = r_list[issue_cfg_pkg::lsu_q_id][i_rd_idx];
                end
            end
            issue_types_pkg::q_csr: begin
                if ({1'b0, i_rd_idx} < r_count[issue_cfg_pkg::csr_q_id]) begin
                    o_rd_instr = r_list[issue_cfg_pkg::csr_q_id][i_rd_idx];
                end
            end
            issue_types_pkg::q_alu: begin
                if (r_alu_valid[i_rd_idx]) begin
                    o_rd_instr = r_alu_q[i_rd_idx];
                end
            end
            default: ;
        endcase
    end

    assign o_batch_done = r_done;
    assign o_lsu_count  = r_count[issue_cfg_pkg::lsu_q_id];
    assign o_csr_count  = r_count[issue_cfg_pkg::csr_q_id];
    assign o_alu_valid  = r_alu_valid;
    assign o_overflow   = r_overflow;

endmodule

`default_nettype wire

/* hdl/class_compact.sv */
`timescale 1ns/10ps
`default_nettype none

module class_compact (
    input  wire                                w_fire00,
    input  wire                                rstn,
    input  wire issue_types_pkg::classified_t  i_cls,
    input  wire                                i_valid,
    output issue_types_pkg::compacted_t        o_cmp
);

    issue_types_pkg::compacted_t w_cmp;
    issue_types_pkg::compacted_t r_cmp;
    logic                        r_valid;

    // ascending walk keeps slot order in both lists
    always_comb begin
        w_cmp = '0;
        for (int i = 0; i < issue_cfg_pkg::slot_count; i++) begin
            case (i_cls.cls[i])
                issue_types_pkg::cls_lsu: begin
                    w_cmp.lsu_list[w_cmp.lsu_count[issue_cfg_pkg::slot_idx_w-1:0]] =
                        i_cls.instr[i];
                    w_cmp.lsu_count = w_cmp.lsu_count + (issue_cfg_pkg::count_w)'(1);
                end
                issue_types_pkg::cls_csr: begin
                    w_cmp.csr_list[w_cmp.csr_count[issue_cfg_pkg::slot_idx_w-1:0]] =
                        i_cls.instr[i];
                    w_cmp.csr_count = w_cmp.csr_count + (issue_cfg_pkg::count_w)'(1);
                end
                issue_types_pkg::cls_alu: begin
                    w_cmp.alu_instr[i] = i_cls.instr[i];   // alu slot keeps its position
                    w_cmp.alu_mask[i]  = 1'b1;
                end
                default: ;
            endcase
        end
        w_cmp.is_first = i_cls.is_first;
    end

    always_ff @(posedge w_fire00 or negedge rstn) begin
        if (!rstn) begin
            r_valid <= 1'b0;
        end else begin
            r_valid <= i_valid;
        end
    end

    always_ff @(posedge w_fire00) begin
        if (i_valid) begin
            r_cmp <= w_cmp;
        end
    end

    // valid comes from the reset flop
    always_comb begin
        o_cmp       = r_cmp;
        o_cmp.valid = r_valid;
    end

endmodule

`default_nettype wire

/* hdl/slot_classify.sv */
`timescale 1ns/10ps
`default_nettype none

module slot_classify (
    input  wire                               w_fire00,
    input  wire                               rstn,
    input  wire issue_types_pkg::batch_t      i_batch,
    input  wire                               i_valid,
    output issue_types_pkg::classified_t      o_cls,
    output logic                              o_valid
);

    logic [issue_cfg_pkg::slot_count-1:0] w_in_window;
    issue_types_pkg::slot_class_e [issue_cfg_pkg::slot_count-1:0] w_cls;

    always_comb begin
        logic [issue_cfg_pkg::slot_idx_w-1:0] idx;
        for (int i = 0; i < issue_cfg_pkg::slot_count; i++) begin
            idx = issue_cfg_pkg::slot_idx_w'(i);
            if (i_batch.is_first) begin
                w_in_window[i] = (idx <= i_batch.first);
            end else if (i_batch.start <= i_batch.stop) begin
                w_in_window[i] = (idx >= i_batch.start) && (idx <= i_batch.stop);
            end else begin
                // wraps past slot 15
                w_in_window[i] = (idx >= i_batch.start) || (idx <= i_batch.stop);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < issue_cfg_pkg::slot_count; i++) begin
            if (!w_in_window[i]) begin
                w_cls[i] = issue_types_pkg::cls_none;
            end else begin
                case (i_batch.instr[i][6:0])
                    issue_types_pkg::op_load,
                    issue_types_pkg::op_store,
                    issue_types_pkg::op_amo:    w_cls[i] = issue_types_pkg::cls_lsu;
                    issue_types_pkg::op_system: w_cls[i] = issue_types_pkg::cls_csr;
                    default:                    w_cls[i] = issue_types_pkg::cls_alu;
                endcase
            end
        end
    end

    always_ff @(posedge w_fire00 or negedge rstn) begin
        if (!rstn) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge w_fire00) begin
        if (i_valid) begin
            o_cls.instr    <= i_batch.instr;
            o_cls.cls      <= w_cls;
            o_cls.is_first <= i_batch.is_first;
        end
    end

endmodule

`default_nettype wire

/* hdl/batch_capture.sv */
`timescale 1ns/10ps
`default_nettype none

module batch_capture (
    input  wire                                   w_fire00,
    input  wire                                   rstn,
    input  wire                                   i_batch_valid,
    input  wire issue_types_pkg::instr_vec_t      i_batch_instr,
    input  wire [issue_cfg_pkg::slot_idx_w-1:0]   i_branch_first,
    input  wire [issue_cfg_pkg::slot_idx_w-1:0]   i_branch_start,
    input  wire [issue_cfg_pkg::slot_idx_w-1:0]   i_branch_stop,
    input  wire                                   i_branch_restart,
    output issue_types_pkg::batch_t               o_batch,
    output logic                                  o_valid
);

    logic r_is_first;   // next captured batch follows a branch

    always_ff @(posedge w_fire00 or negedge rstn) begin
        if (!rstn) begin
            o_valid    <= 1'b0;
            r_is_first <= 1'b1;
        end else begin
            o_valid <= i_batch_valid;
            // restart wins, so a restart with a strobe marks the batch after
            if (i_branch_restart) begin
                r_is_first <= 1'b1;
            end else if (i_batch_valid) begin
                r_is_first <= 1'b0;
            end
        end
    end

    always_ff @(posedge w_fire00) begin
        if (i_batch_valid) begin
            o_batch.instr    <= i_batch_instr;
            o_batch.first    <= i_branch_first;
            o_batch.start    <= i_branch_start;
            o_batch.stop     <= i_branch_stop;
            o_batch.is_first <= r_is_first;    // flag before this edge
        end
    end

endmodule

`default_nettype wire

/* hdl/issue_types_pkg.sv */
`default_nettype none

package issue_types_pkg;

    typedef enum logic [6:0] {
        op_load   = issue_cfg_pkg::opc_load,
        op_store  = issue_cfg_pkg::opc_store,
        op_amo    = issue_cfg_pkg::opc_amo,
        op_system = issue_cfg_pkg::opc_system
    } opcode_e;

    typedef enum logic [1:0] {
        cls_none,   // outside the branch window
        cls_alu,
        cls_lsu,
        cls_csr
    } slot_class_e;

    // read port queue select
    typedef enum logic [1:0] {
        q_alu,
        q_lsu,
        q_csr
    } queue_sel_e;

    // slot 0 at index 0
    typedef logic [issue_cfg_pkg::slot_count-1:0][issue_cfg_pkg::instr_w-1:0] instr_vec_t;

    typedef struct packed {
        instr_vec_t                          instr;
        logic [issue_cfg_pkg::slot_idx_w-1:0] first;
        logic [issue_cfg_pkg::slot_idx_w-1:0] start;
        logic [issue_cfg_pkg::slot_idx_w-1:0] stop;
        logic                                is_first;
    } batch_t;

    typedef struct packed {
        instr_vec_t                                instr;
        slot_class_e [issue_cfg_pkg::slot_count-1:0] cls;
        logic                                      is_first;
    } classified_t;

    typedef struct packed {
        instr_vec_t                          lsu_list;
        logic [issue_cfg_pkg::count_w-1:0]    lsu_count;
        instr_vec_t                          csr_list;
        logic [issue_cfg_pkg::count_w-1:0]    csr_count;
        instr_vec_t                          alu_instr;
        logic [issue_cfg_pkg::slot_count-1:0] alu_mask;
        logic                                is_first;
        logic                                valid;
    } compacted_t;

endpackage

`default_nettype wire

/* hdl/issue_cfg_pkg.sv */
`default_nettype none

package issue_cfg_pkg;

    localparam int slot_count  = 16;
    localparam int slot_idx_w  = 4;     // slot index and queue index
    localparam int count_w     = 5;     // fill count 0..16
    localparam int instr_w     = 32;
    localparam int queue_depth = 16;    // lsu and csr queues

    // lsu and csr list queues live in one array
    localparam int list_queue_count = 2;
    localparam int lsu_q_id         = 0;
    localparam int csr_q_id         = 1;

    // riscv major opcodes, bits 6:0
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_amo    = 7'b0101111;
    localparam logic [6:0] opc_system = 7'b1110011;

endpackage

`default_nettype wire
